// File: sources.f
+incdir+rtl
rtl/vrf_types_pkg.sv
rtl/opreq_ctrl_pkg.sv
rtl/vrf_access_if.sv
rtl/operand_fetcher.sv
rtl/result_skid_reg.sv
rtl/vrf_arbiter.sv
rtl/operand_requester.sv
verif/tb_operand_requester.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       ?= tb_operand_requester
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# Output is kept in a shell variable so that it can be shown and searched
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_operand_requester.sv
`timescale 1ns/100ps
`default_nettype none

`include "opreq_settings.svh"

module tb_operand_requester;

  import vrf_types_pkg::*;
  import opreq_ctrl_pkg::*;

  localparam int CLK_PERIOD = 100;
  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 200;

  logic                                clk;
  logic                                rst_n;
  operand_request_t [`NR_OPQUEUES-1:0] op_req;
  logic [`NR_OPQUEUES-1:0]             op_req_valid;
  logic [`NR_OPQUEUES-1:0]             op_req_ready;
  logic [`NR_OPQUEUES-1:0]             queue_ready;
  logic [`NR_OPQUEUES-1:0]             issued;
  opqueue_cmd_t [`NR_OPQUEUES-1:0]     queue_cmd;
  logic [`NR_OPQUEUES-1:0]             queue_cmd_valid;
  logic [`NR_BANKS-1:0]                vrf_req;
  bank_addr_t [`NR_BANKS-1:0]          vrf_addr;
  logic [`NR_BANKS-1:0]                vrf_wen;
  elen_t [`NR_BANKS-1:0]               vrf_wdata;
  strb_t [`NR_BANKS-1:0]               vrf_be;
  opqueue_e [`NR_BANKS-1:0]            vrf_tgt;
  logic                                alu_req;
  vaddr_t                              alu_addr;
  elen_t                               alu_wdata;
  strb_t                               alu_be;
  logic                                alu_gnt;
  logic                                ldu_req;
  vaddr_t                              ldu_addr;
  elen_t                               ldu_wdata;
  strb_t                               ldu_be;
  logic                                ldu_gnt;
  logic                                ldu_final_gnt;

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard state
  ////////////////////////////////////////////////////////////////////////////

  // Expected read addresses per queue, in issue order
  vaddr_t exp_rd [`NR_OPQUEUES][$];
  vaddr_t exp_wr_addr [$];
  elen_t  exp_wr_data [$];
  strb_t  exp_wr_be [$];
  // Last command per queue, for the queue command check
  int     exp_vl [`NR_OPQUEUES];
  int     exp_eew [`NR_OPQUEUES];
  int     cycle;
  int     last_write_cycle;
  string  test_name;
  int     errors;
  int     errors_before;
  int     tests_run;
  int     tests_failed;
  integer seed;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  operand_requester dut0 (
    .clk_i                    (clk),
    .rst_ni                   (rst_n),
    .operand_request_i        (op_req),
    .operand_request_valid_i  (op_req_valid),
    .operand_request_ready_o  (op_req_ready),
    .operand_queue_ready_i    (queue_ready),
    .operand_issued_o         (issued),
    .operand_queue_cmd_o      (queue_cmd),
    .operand_queue_cmd_valid_o(queue_cmd_valid),
    .vrf_req_o                (vrf_req),
    .vrf_addr_o               (vrf_addr),
    .vrf_wen_o                (vrf_wen),
    .vrf_wdata_o              (vrf_wdata),
    .vrf_be_o                 (vrf_be),
    .vrf_tgt_opqueue_o        (vrf_tgt),
    .alu_result_req_i         (alu_req),
    .alu_result_addr_i        (alu_addr),
    .alu_result_wdata_i       (alu_wdata),
    .alu_result_be_i          (alu_be),
    .alu_result_gnt_o         (alu_gnt),
    .ldu_result_req_i         (ldu_req),
    .ldu_result_addr_i        (ldu_addr),
    .ldu_result_wdata_i       (ldu_wdata),
    .ldu_result_be_i          (ldu_be),
    .ldu_result_gnt_o         (ldu_gnt),
    .ldu_result_final_gnt_o   (ldu_final_gnt)
  );

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[FAIL] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error in %s: %s", test_name, msg);
    errors++;
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [`NR_OPQUEUES-1:0] one_hot(input int q);
    logic [`NR_OPQUEUES-1:0] mask;
    mask    = '0;
    mask[q] = 1'b1;
    return mask;
  endfunction

  // Words for vl elements of width eew, last one may be partial
  function automatic int expected_words(input int vl, input int eew);
    int per_word;
    per_word = (`ELEN / 8) >> eew;
    return (vl + per_word - 1) / per_word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // VRF port checker
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : vrf_check
    int     t;
    vaddr_t exp_a;
    for (int b = 0; b < `NR_BANKS; b++) begin
      if (vrf_req[b] && !vrf_wen[b]) begin
        // Read routed back to the queue named by tgt
        t = int'(vrf_tgt[b]);
        assert (exp_rd[t].size() != 0)
          else report_problem($sformatf("unexpected read on bank %0d for queue %0d", b, t));
        if (exp_rd[t].size() != 0) begin
          exp_a = exp_rd[t].pop_front();
          assert (b == int'(exp_a[1:0])) else report_mismatch("read bank", exp_a[1:0], b);
          assert (vrf_addr[b] == exp_a[7:2])
            else report_mismatch("read bank address", exp_a[7:2], vrf_addr[b]);
        end
      end else if (vrf_req[b]) begin
        last_write_cycle = cycle;
        assert (exp_wr_addr.size() != 0)
          else report_problem($sformatf("unexpected write on bank %0d", b));
        if (exp_wr_addr.size() != 0) begin
          exp_a = exp_wr_addr.pop_front();
          assert (b == int'(exp_a[1:0])) else report_mismatch("write bank", exp_a[1:0], b);
          assert (vrf_addr[b] == exp_a[7:2])
            else report_mismatch("write bank address", exp_a[7:2], vrf_addr[b]);
          assert (vrf_wdata[b] == exp_wr_data[0])
            else report_mismatch("write data", exp_wr_data[0], vrf_wdata[b]);
          assert (vrf_be[b] == exp_wr_be[0])
            else report_mismatch("write strobe", exp_wr_be[0], vrf_be[b]);
          void'(exp_wr_data.pop_front());
          void'(exp_wr_be.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Call right after a rising edge
  task automatic load_command(input int q, input int vs, input int vl, input int eew);
    operand_request_t cmd;
    cmd.vs          = vreg_t'(vs);
    cmd.vl          = vlen_t'(vl);
    cmd.eew         = vew_e'(eew);
    op_req[q]       <= cmd;
    op_req_valid[q] <= 1'b1;
    exp_vl[q]       = vl;
    exp_eew[q]      = eew;
    for (int i = 0; i < expected_words(vl, eew); i++) begin
      exp_rd[q].push_back(vaddr_t'(vs * `VREG_WORDS + i));
    end
  endtask

  // Handshake for all queues in mask, then drop their valid
  task automatic send_commands(input logic [`NR_OPQUEUES-1:0] mask);
    int n;
    n = 0;
    @(negedge clk);
    while ((op_req_ready & mask) != mask && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (n < WAIT_LIMIT) else report_problem("request ready never came");
    for (int q = 0; q < `NR_OPQUEUES; q++) begin
      if (mask[q]) begin
        assert (queue_cmd_valid[q] == (exp_vl[q] != 0))
          else report_mismatch("command valid", exp_vl[q] != 0, queue_cmd_valid[q]);
        if (exp_vl[q] != 0) begin
          assert (queue_cmd[q].elem_count == vlen_t'(exp_vl[q]))
            else report_mismatch("elem_count", exp_vl[q], queue_cmd[q].elem_count);
          assert (queue_cmd[q].eew == vew_e'(exp_eew[q]))
            else report_mismatch("command eew", exp_eew[q], queue_cmd[q].eew);
        end
      end
    end
    @(posedge clk);
    op_req_valid <= op_req_valid & ~mask;
  endtask

  // Sampled on the rising edge, after the checker has run
  task automatic wait_reads_done(input int q);
    int n;
    n = 0;
    while (exp_rd[q].size() != 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    assert (n < WAIT_LIMIT)
      else report_problem($sformatf("reads for queue %0d did not finish", q));
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errors_before = errors;
  endtask

  task automatic end_test();
    for (int q = 0; q < `NR_OPQUEUES; q++) begin
      assert (exp_rd[q].size() == 0)
        else report_problem($sformatf("queue %0d is missing reads", q));
    end
    assert (exp_wr_addr.size() == 0) else report_problem("a result write never reached the VRF");
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int     n;
    vaddr_t wr_addr;
    elen_t  wr_data;
    strb_t  wr_be;
    seed             = 80;
    cycle            = 0;
    last_write_cycle = -1;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    test_name        = "reset";
    rst_n            = 1'b0;
    op_req           = '0;
    op_req_valid     = '0;
    queue_ready      = '1;
    alu_req          = 1'b0;
    alu_addr         = '0;
    alu_wdata        = '0;
    alu_be           = '0;
    ldu_req          = 1'b0;
    ldu_addr         = '0;
    ldu_wdata        = '0;
    ldu_be           = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // One random stream per queue
    start_test("single_read");
    for (int q = 0; q < `NR_OPQUEUES; q++) begin
      @(posedge clk);
      load_command(q, rand_below(32), 1 + rand_below(64), rand_below(4));
      send_commands(one_hot(q));
      wait_reads_done(q);
      idle(3);
    end
    end_test();

    // Ack only, checker flags any read
    start_test("zero_length");
    @(posedge clk);
    load_command(3, rand_below(32), 0, rand_below(4));
    send_commands(one_hot(3));
    idle(4);
    end_test();

    start_test("back_pressure");
    @(posedge clk);
    queue_ready[1] <= 1'b0;
    load_command(1, rand_below(32), 1 + rand_below(64), rand_below(4));
    send_commands(one_hot(1));
    repeat (6) begin
      @(negedge clk);
      assert (!issued[1]) else report_problem("queue 1 read while its queue was full");
    end
    @(posedge clk);
    queue_ready[1] <= 1'b1;
    wait_reads_done(1);
    idle(3);
    end_test();

    // Write is granted in the cycle it is driven
    start_test("alu_write");
    @(posedge clk);
    wr_addr = vaddr_t'($random(seed));
    wr_data = elen_t'({$random(seed), $random(seed)});
    wr_be   = strb_t'($random(seed));
    exp_wr_addr.push_back(wr_addr);
    exp_wr_data.push_back(wr_data);
    exp_wr_be.push_back(wr_be);
    alu_req   <= 1'b1;
    alu_addr  <= wr_addr;
    alu_wdata <= wr_data;
    alu_be    <= wr_be;
    @(negedge clk);
    n = 0;
    while (!alu_gnt && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (n < WAIT_LIMIT) else report_problem("ALU result was never granted");
    @(posedge clk);
    alu_req <= 1'b0;
    idle(3);
    end_test();

    // Both streams start on bank 0 in the same cycle
    start_test("priority");
    @(posedge clk);
    load_command(0, rand_below(32), 1 + rand_below(64), rand_below(4));
    load_command(2, rand_below(32), 1 + rand_below(64), rand_below(4));
    send_commands(4'b0101);
    @(negedge clk);
    assert (vrf_req[0] && vrf_tgt[0] == ALU_A)
      else report_problem("queue 0 did not win the shared bank");
    assert (issued[0] && !issued[2])
      else report_problem("queue 2 was granted against queue 0");
    wait_reads_done(0);
    wait_reads_done(2);
    idle(3);
    end_test();

    start_test("load_write");
    @(posedge clk);
    wr_addr = vaddr_t'($random(seed));
    wr_data = elen_t'({$random(seed), $random(seed)});
    wr_be   = strb_t'($random(seed));
    exp_wr_addr.push_back(wr_addr);
    exp_wr_data.push_back(wr_data);
    exp_wr_be.push_back(wr_be);
    ldu_req   <= 1'b1;
    ldu_addr  <= wr_addr;
    ldu_wdata <= wr_data;
    ldu_be    <= wr_be;
    @(negedge clk);
    n = 0;
    while (!ldu_gnt && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (n < WAIT_LIMIT) else report_problem("load result was never accepted");
    @(posedge clk);
    ldu_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!ldu_final_gnt && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (n < WAIT_LIMIT) else report_problem("load final grant never rose");
    // Final grant one cycle behind the VRF write
    assert (cycle == last_write_cycle + 1)
      else report_mismatch("final grant cycle", last_write_cycle + 1, cycle);
    idle(3);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/operand_requester.sv
`timescale 1ns/100ps
`default_nettype none

`include "opreq_settings.svh"

module operand_requester (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // Lane sequencer commands
  input  opreq_ctrl_pkg::operand_request_t [`NR_OPQUEUES-1:0] operand_request_i,
  input  logic                             [`NR_OPQUEUES-1:0] operand_request_valid_i,
  output logic                             [`NR_OPQUEUES-1:0] operand_request_ready_o,
  // Operand queues
  input  logic                             [`NR_OPQUEUES-1:0] operand_queue_ready_i,
  output logic                             [`NR_OPQUEUES-1:0] operand_issued_o,
  output opreq_ctrl_pkg::opqueue_cmd_t     [`NR_OPQUEUES-1:0] operand_queue_cmd_o,
  output logic                             [`NR_OPQUEUES-1:0] operand_queue_cmd_valid_o,
  // VRF banks
  output logic                             [`NR_BANKS-1:0]    vrf_req_o,
  output vrf_types_pkg::bank_addr_t        [`NR_BANKS-1:0]    vrf_addr_o,
  output logic                             [`NR_BANKS-1:0]    vrf_wen_o,
  output vrf_types_pkg::elen_t             [`NR_BANKS-1:0]    vrf_wdata_o,
  output vrf_types_pkg::strb_t             [`NR_BANKS-1:0]    vrf_be_o,
  output opreq_ctrl_pkg::opqueue_e         [`NR_BANKS-1:0]    vrf_tgt_opqueue_o,
  // ALU results
  input  logic                                              alu_result_req_i,
  input  vrf_types_pkg::vaddr_t                             alu_result_addr_i,
  input  vrf_types_pkg::elen_t                              alu_result_wdata_i,
  input  vrf_types_pkg::strb_t                              alu_result_be_i,
  output logic                                              alu_result_gnt_o,
  // Load-unit results
  input  logic                                              ldu_result_req_i,
  input  vrf_types_pkg::vaddr_t                             ldu_result_addr_i,
  input  vrf_types_pkg::elen_t                              ldu_result_wdata_i,
  input  vrf_types_pkg::strb_t                              ldu_result_be_i,
  output logic                                              ldu_result_gnt_o,
  output logic                                              ldu_result_final_gnt_o
);

  import opreq_ctrl_pkg::*;

  // One access port per master
  vrf_access_if vrf_if [`NR_MASTERS] ();

  ////////////////////////////////////////////////////////////////////////////
  // Operand fetchers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar q = 0; q < `NR_OPQUEUES; q++) begin : g_fetch
    // Read data routed back to this queue
    assign vrf_if[q].tgt = opqueue_e'(q);

    operand_fetcher i_fetcher (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .request_i      (operand_request_i[q]),
      .request_valid_i(operand_request_valid_i[q]),
      .request_ready_o(operand_request_ready_o[q]),
      .queue_ready_i  (operand_queue_ready_i[q]),
      .cmd_o          (operand_queue_cmd_o[q]),
      .cmd_valid_o    (operand_queue_cmd_valid_o[q]),
      .issued_o       (operand_issued_o[q]),
      .vrf            (vrf_if[q])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result write ports
  ////////////////////////////////////////////////////////////////////////////

  // ALU goes straight to the arbiters
  assign vrf_if[`ALU_MASTER].req   = alu_result_req_i;
  assign vrf_if[`ALU_MASTER].addr  = alu_result_addr_i;
  assign vrf_if[`ALU_MASTER].wen   = 1'b1;
  assign vrf_if[`ALU_MASTER].wdata = alu_result_wdata_i;
  assign vrf_if[`ALU_MASTER].be    = alu_result_be_i;
  assign vrf_if[`ALU_MASTER].tgt   = ALU_A;
  assign alu_result_gnt_o          = vrf_if[`ALU_MASTER].gnt;

  // Load unit behind a one-entry register
  assign vrf_if[`LDU_MASTER].tgt = ALU_A;

  result_skid_reg i_ldu_skid (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(ldu_result_req_i),
    .ready_o(ldu_result_gnt_o),
    .addr_i (ldu_result_addr_i),
    .wdata_i(ldu_result_wdata_i),
    .be_i   (ldu_result_be_i),
    .out    (vrf_if[`LDU_MASTER])
  );

  // Final grant marks the cycle after the actual VRF write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_result_final_gnt_o <= 1'b0;
    end else begin
      ldu_result_final_gnt_o <= vrf_if[`LDU_MASTER].gnt;
    end
  end

  vrf_arbiter i_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .masters          (vrf_if),
    .vrf_req_o        (vrf_req_o),
    .vrf_addr_o       (vrf_addr_o),
    .vrf_wen_o        (vrf_wen_o),
    .vrf_wdata_o      (vrf_wdata_o),
    .vrf_be_o         (vrf_be_o),
    .vrf_tgt_opqueue_o(vrf_tgt_opqueue_o)
  );

endmodule

`default_nettype wire

// File: rtl/vrf_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "opreq_settings.svh"

module vrf_arbiter (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // All masters, queues first
  vrf_access_if.arbiter                             masters [`NR_MASTERS],
  // Per-bank VRF port
  output logic                     [`NR_BANKS-1:0]  vrf_req_o,
  output vrf_types_pkg::bank_addr_t [`NR_BANKS-1:0] vrf_addr_o,
  output logic                     [`NR_BANKS-1:0]  vrf_wen_o,
  output vrf_types_pkg::elen_t     [`NR_BANKS-1:0]  vrf_wdata_o,
  output vrf_types_pkg::strb_t     [`NR_BANKS-1:0]  vrf_be_o,
  output opreq_ctrl_pkg::opqueue_e [`NR_BANKS-1:0]  vrf_tgt_opqueue_o
);

  import vrf_types_pkg::*;
  import opreq_ctrl_pkg::*;

  localparam int BANK_W   = $clog2(`NR_BANKS);
  localparam int GRP_SIZE = 3;
  localparam int PTR_W    = $clog2(GRP_SIZE);
  // Group 0 is high priority, group 1 low
  localparam int GRP_MEMBER [2][GRP_SIZE] = '{'{0, 1, `ALU_MASTER}, '{2, 3, `LDU_MASTER}};

  logic     [`NR_MASTERS-1:0] m_req;
  vaddr_t                     m_addr [`NR_MASTERS];
  logic     [`NR_MASTERS-1:0] m_wen;
  elen_t                      m_wdata [`NR_MASTERS];
  strb_t                      m_be [`NR_MASTERS];
  opqueue_e                   m_tgt [`NR_MASTERS];
  logic     [`NR_MASTERS-1:0] m_gnt;

  logic [GRP_SIZE-1:0]    grp_req [`NR_BANKS][2];
  logic [GRP_SIZE-1:0]    grp_gnt [`NR_BANKS][2];
  logic [GRP_SIZE-1:0]    grp_win [`NR_BANKS][2];
  logic [PTR_W-1:0]       ptr_q [`NR_BANKS][2];
  logic [PTR_W-1:0]       ptr_d [`NR_BANKS][2];
  logic [`NR_MASTERS-1:0] bank_win [`NR_BANKS];
  logic [`NR_BANKS-1:0]   hp_any;

  // Flatten the interfaces
  for (genvar m = 0; m < `NR_MASTERS; m++) begin : g_master
    assign m_req[m]       = masters[m].req;
    assign m_addr[m]      = masters[m].addr;
    assign m_wen[m]       = masters[m].wen;
    assign m_wdata[m]     = masters[m].wdata;
    assign m_be[m]        = masters[m].be;
    assign m_tgt[m]       = masters[m].tgt;
    assign masters[m].gnt = m_gnt[m];
  end

  // First requester at or after the pointer
  function automatic logic [GRP_SIZE-1:0] rr_pick(input logic [GRP_SIZE-1:0] req,
                                                 input logic [PTR_W-1:0]    ptr);
    logic [GRP_SIZE-1:0] gnt;
    int                  idx;
    gnt = '0;
    for (int i = GRP_SIZE - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % GRP_SIZE;
      if (req[idx]) begin
        gnt      = '0;
        gnt[idx] = 1'b1;
      end
    end
    return gnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Two-level arbitration per bank
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    m_gnt = '0;
    for (int b = 0; b < `NR_BANKS; b++) begin
      bank_win[b] = '0;
      // Bank decode from the low address bits
      for (int g = 0; g < 2; g++) begin
        for (int k = 0; k < GRP_SIZE; k++) begin
          grp_req[b][g][k] = m_req[GRP_MEMBER[g][k]] &&
                             (m_addr[GRP_MEMBER[g][k]][BANK_W-1:0] == BANK_W'(b));
        end
        grp_gnt[b][g] = rr_pick(grp_req[b][g], ptr_q[b][g]);
      end
      // High group masks the low one
      hp_any[b]     = |grp_req[b][0];
      grp_win[b][0] = grp_gnt[b][0];
      grp_win[b][1] = hp_any[b] ? '0 : grp_gnt[b][1];
      for (int g = 0; g < 2; g++) begin
        ptr_d[b][g] = ptr_q[b][g];
        for (int k = 0; k < GRP_SIZE; k++) begin
          bank_win[b][GRP_MEMBER[g][k]] = grp_win[b][g][k];
          // Winner goes to the back
          if (grp_win[b][g][k]) begin
            ptr_d[b][g] = PTR_W'((k + 1) % GRP_SIZE);
          end
        end
      end
      m_gnt = m_gnt | bank_win[b];
    end
  end

  // Bank port mux, every request is taken
  always_comb begin
    for (int b = 0; b < `NR_BANKS; b++) begin
      vrf_req_o[b]         = |bank_win[b];
      vrf_addr_o[b]        = '0;
      vrf_wen_o[b]         = 1'b0;
      vrf_wdata_o[b]       = '0;
      vrf_be_o[b]          = '0;
      vrf_tgt_opqueue_o[b] = ALU_A;
      for (int m = 0; m < `NR_MASTERS; m++) begin
        if (bank_win[b][m]) begin
          vrf_addr_o[b]        = bank_addr_t'(m_addr[m] >> BANK_W);
          vrf_wen_o[b]         = m_wen[m];
          vrf_wdata_o[b]       = m_wdata[m];
          vrf_be_o[b]          = m_be[m];
          vrf_tgt_opqueue_o[b] = m_tgt[m];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < `NR_BANKS; b++) begin
        for (int g = 0; g < 2; g++) begin
          ptr_q[b][g] <= '0;
        end
      end
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/result_skid_reg.sv
`timescale 1ns/100ps
`default_nettype none

module result_skid_reg (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Result from the load unit
  input  logic                  valid_i,
  output logic                  ready_o,
  input  vrf_types_pkg::vaddr_t addr_i,
  input  vrf_types_pkg::elen_t  wdata_i,
  input  vrf_types_pkg::strb_t  be_i,
  // Write request toward the bank arbiters
  vrf_access_if.master          out
);

  import vrf_types_pkg::*;

  logic   valid_q;
  vaddr_t addr_q;
  elen_t  wdata_q;
  strb_t  be_q;

  // Take a pending result when empty or draining
  assign ready_o = valid_i && (!valid_q || out.gnt);

  // Held entry is a write
  assign out.req   = valid_q;
  assign out.addr  = addr_q;
  assign out.wen   = 1'b1;
  assign out.wdata = wdata_q;
  assign out.be    = be_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o || out.gnt) begin
      valid_q <= ready_o;
    end
  end

  // Payload, loaded on accept
  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/operand_fetcher.sv
`timescale 1ns/100ps
`default_nettype none

`include "opreq_settings.svh"

module operand_fetcher (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Command from the lane sequencer
  input  opreq_ctrl_pkg::operand_request_t request_i,
  input  logic                             request_valid_i,
  output logic                             request_ready_o,
  // Operand queue side
  input  logic                             queue_ready_i,
  output opreq_ctrl_pkg::opqueue_cmd_t     cmd_o,
  output logic                             cmd_valid_o,
  output logic                             issued_o,
  // Read port toward the bank arbiters
  vrf_access_if.master                     vrf
);

  import vrf_types_pkg::*;
  import opreq_ctrl_pkg::*;

  fetch_state_e state_q, state_d;
  // Next word to read
  vaddr_t       addr_q, addr_d;
  // Elements still to fetch
  vlen_t        len_q, len_d;
  vew_e         eew_q, eew_d;
  // Elements covered by one word
  vlen_t        step;
  // Free to take a new command this cycle
  logic         accept;

  assign step = vlen_t'((`ELEN / 8) >> eew_q);

  // Queue command comes straight from the request
  assign cmd_o = '{eew: request_i.eew, elem_count: request_i.vl};

  // Reads only, from the current word
  assign vrf.addr  = addr_q;
  assign vrf.wen   = 1'b0;
  assign vrf.wdata = '0;
  assign vrf.be    = '0;

  // One word goes out per grant
  assign issued_o = vrf.gnt;

  ////////////////////////////////////////////////////////////////////////////
  // Requester FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    addr_d          = addr_q;
    len_d           = len_q;
    eew_d           = eew_q;
    accept          = 1'b0;
    vrf.req         = 1'b0;
    request_ready_o = 1'b0;
    cmd_valid_o     = 1'b0;

    case (state_q)
      IDLE: begin
        accept = 1'b1;
      end
      REQUESTING: begin
        // Queue full, hold the request off
        if (queue_ready_i) begin
          vrf.req = 1'b1;
          if (vrf.gnt) begin
            addr_d = addr_q + 1'b1;
            // Last word may be partly filled
            len_d  = (len_q > step) ? len_q - step : '0;
          end
        end
        // Done, next command can follow back to back
        if (len_d == '0) begin
          state_d = IDLE;
          accept  = 1'b1;
        end
      end
    endcase

    if (accept && request_valid_i) begin
      request_ready_o = 1'b1;
      // Register base in the lane's word space
      addr_d          = vaddr_t'(request_i.vs * `VREG_WORDS);
      len_d           = request_i.vl;
      eew_d           = request_i.eew;
      // Empty vector, ack only
      if (request_i.vl != '0) begin
        cmd_valid_o = 1'b1;
        state_d     = REQUESTING;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      len_q   <= '0;
    end else begin
      state_q <= state_d;
      len_q   <= len_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    eew_q  <= eew_d;
  end

endmodule

`default_nettype wire

// File: rtl/vrf_access_if.sv
`timescale 1ns/100ps
`default_nettype none

interface vrf_access_if;

  import vrf_types_pkg::*;
  import opreq_ctrl_pkg::*;

  // Access request, held until granted
  logic     req;
  vaddr_t   addr;
  logic     wen;
  elen_t    wdata;
  strb_t    be;
  // Read destination, tied per master at the top
  opqueue_e tgt;
  // Same-cycle grant from the bank arbiter
  logic     gnt;

  // Requesting side
  modport master (
    output req, addr, wen, wdata, be,
    input  gnt
  );

  // Bank arbiter side
  modport arbiter (
    input  req, addr, wen, wdata, be, tgt,
    output gnt
  );

endinterface

`default_nettype wire

// File: rtl/opreq_ctrl_pkg.sv
`default_nettype none

package opreq_ctrl_pkg;

  import vrf_types_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Requester control types
  ////////////////////////////////////////////////////////////////////////////

  // Target queue, also routes VRF read data
  typedef enum logic [1:0] {
    ALU_A,
    ALU_B,
    MASK_A,
    MASK_B
  } opqueue_e;

  // Per-queue requester FSM
  typedef enum logic {
    IDLE,
    REQUESTING
  } fetch_state_e;

  // Command from the lane sequencer
  typedef struct packed {
    vreg_t vs;
    vlen_t vl;
    vew_e  eew;
  } operand_request_t;

  // Conversion command to the operand queue
  typedef struct packed {
    vew_e  eew;
    vlen_t elem_count;
  } opqueue_cmd_t;

endpackage

`default_nettype wire

// File: rtl/vrf_types_pkg.sv
`default_nettype none

`include "opreq_settings.svh"

package vrf_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // VRF word and address types
  ////////////////////////////////////////////////////////////////////////////

  // One VRF word
  typedef logic [`ELEN-1:0] elen_t;
  // Byte enables of one word
  typedef logic [`ELEN/8-1:0] strb_t;
  // Word address across all banks
  typedef logic [`VADDR_W-1:0] vaddr_t;
  // Word address inside one bank
  typedef logic [`VADDR_W-$clog2(`NR_BANKS)-1:0] bank_addr_t;
  // Element count, up to a full register of bytes
  typedef logic [$clog2(`VREG_WORDS*8+1)-1:0] vlen_t;
  // Architectural register number
  typedef logic [4:0] vreg_t;

  // Element width
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

endpackage

`default_nettype wire

// File: rtl/opreq_settings.svh
`ifndef OPREQ_SETTINGS_SVH
`define OPREQ_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Lane geometry
////////////////////////////////////////////////////////////////////////////

// VRF banks in one lane
`define NR_BANKS 4
// Operand queues, one requester each
`define NR_OPQUEUES 4
// Bits per VRF word
`define ELEN 64
// 64-bit words per vector register in this lane
`define VREG_WORDS 8
// Lane-global word address, low bits pick the bank
`define VADDR_W 8

// Arbiter masters: the queues, then the ALU and load-unit write ports
`define NR_MASTERS (`NR_OPQUEUES + 2)
`define ALU_MASTER (`NR_OPQUEUES)
`define LDU_MASTER (`NR_OPQUEUES + 1)

`endif
